// ==== rtl/pit_pkg.sv ====
// Interval timer shared definitions
// Bus and count widths, plus the control word field encodings
// used by every block of the counter channel

`default_nettype none

package pit_pkg;

    // One byte on the CPU bus
    typedef logic [7:0] byte_t;

    // Count value as written by software
    typedef logic [15:0] preset_t;

    // Working count with bit 16 standing for 65536
    typedef logic [16:0] count_t;

    // Read/load field of the control word
    typedef logic [1:0] rw_sel_t;

    // Mode field of the control word
    typedef logic [2:0] mode_t;

    localparam rw_sel_t RW_LATCH   = 2'd0;
    localparam rw_sel_t RW_MSB     = 2'd1;
    localparam rw_sel_t RW_LSB     = 2'd2;
    localparam rw_sel_t RW_LSB_MSB = 2'd3;

    localparam mode_t MODE_TERMINAL = 3'd0;
    localparam mode_t MODE_RATE     = 3'd2;

    // Field positions inside the control word
    // The BCD flag sits in bit 0
    localparam int RW_FIELD_LSB   = 4;
    localparam int MODE_FIELD_LSB = 1;

endpackage

`default_nettype wire

// ==== rtl/pit_mode_register.sv ====
// Timer mode register
// Splits control words into latch commands and new configurations,
// and holds the read/load selection, the mode and the BCD flag

`timescale 1ns/1ps
`default_nettype none

module pit_mode_register import pit_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  byte_t   data_in,
    input  logic    write_control,
    output rw_sel_t rw_sel,
    output mode_t   mode,
    output logic    bcd,
    output logic    config_write,
    output logic    latch_cmd
);

    rw_sel_t rw_field;
    mode_t   mode_field;

    assign rw_field   = data_in[RW_FIELD_LSB +: 2];
    assign mode_field = data_in[MODE_FIELD_LSB +: 3];

    assign latch_cmd    = write_control && (rw_field == RW_LATCH);
    assign config_write = write_control && (rw_field != RW_LATCH);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rw_sel <= RW_MSB;
            mode   <= MODE_TERMINAL;
            bcd    <= 1'b0;
        end else if (config_write) begin
            rw_sel <= rw_field;
            // Mode 6 behaves as mode 2
            if (mode_field[1:0] == 2'b10)
                mode <= MODE_RATE;
            else
                mode <= mode_field;
            bcd    <= data_in[0];
        end
    end

    // A latch command leaves the configuration alone
    a_latch_keeps_config: assert property (@(posedge clock) disable iff (reset)
        latch_cmd |=> ($stable(rw_sel) && $stable(mode) && $stable(bcd)));

endmodule

`default_nettype wire

// ==== rtl/pit_preset_loader.sv ====
// Timer preset loader
// Builds the 16-bit preset from one or two bus byte writes,
// flags a pending load for the next counter clock edge and
// arms counting once the preset is complete

`timescale 1ns/1ps
`default_nettype none

module pit_preset_loader import pit_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  byte_t   data_in,
    input  logic    write_counter,
    input  logic    config_write,
    input  rw_sel_t rw_sel,
    input  logic    count_edge,
    output count_t  preset_load,
    output logic    load_pending,
    output logic    counting
);

    preset_t preset;
    preset_t preset_masked;
    logic    write_step;
    logic    write_msb;

    // Second byte of a two-byte write goes to the top half
    assign write_msb = (rw_sel == RW_MSB) || ((rw_sel == RW_LSB_MSB) && write_step);

    always_ff @(posedge clock) begin
        if (write_counter) begin
            if (write_msb)
                preset[15:8] <= data_in;
            else
                preset[7:0] <= data_in;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            write_step <= 1'b0;
        else if (config_write)
            write_step <= 1'b0;
        else if (write_counter && (rw_sel == RW_LSB_MSB))
            write_step <= ~write_step;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            counting <= 1'b0;
        end else if (config_write) begin
            counting <= 1'b0;
        end else if (write_counter) begin
            // Two-byte writes stop the count until the MSB arrives
            if (rw_sel == RW_LSB_MSB)
                counting <= write_step;
            else
                counting <= 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            load_pending <= 1'b0;
        else if (write_counter)
            load_pending <= 1'b1;
        else if (count_edge)
            load_pending <= 1'b0;
    end

    always_comb begin
        case (rw_sel)
            RW_MSB:  preset_masked = {preset[15:8], 8'h00};
            RW_LSB:  preset_masked = {8'h00, preset[7:0]};
            default: preset_masked = preset;
        endcase
        // A zero preset counts the full 65536
        preset_load = {(preset_masked == 16'h0000), preset_masked};
    end

    // Counting is never armed halfway through a two-byte preset
    a_armed_after_msb: assert property (@(posedge clock) disable iff (reset)
        (counting && (rw_sel == RW_LSB_MSB)) |-> !write_step);

endmodule

`default_nettype wire

// ==== rtl/pit_count_engine.sv ====
// Timer count engine
// Samples the counter clock and gate, decrements the count in
// binary or BCD on each counter clock falling edge, reloads the
// preset and drives the output pin for modes 0 and 2

`timescale 1ns/1ps
`default_nettype none

module pit_count_engine import pit_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   counter_clock,
    input  logic   counter_gate,
    input  mode_t  mode,
    input  logic   bcd,
    input  count_t preset_load,
    input  logic   load_pending,
    input  logic   counting,
    output count_t count,
    output logic   count_edge,
    output logic   counter_out
);

    logic   clock_sample;
    logic   clock_prev;
    logic   gate_sample;
    count_t count_dec;
    count_t count_next;

    function automatic count_t decrement(input count_t value, input logic is_bcd);
        count_t result;
        logic   borrow;
        result = value;
        borrow = 1'b1;
        if (value == '0) begin
            result = '0;
        end else if (!is_bcd) begin
            result = value - 17'd1;
        end else begin
            // Ripple the borrow through four decimal digits
            for (int d = 0; d < 4; d++) begin
                if (borrow) begin
                    if (value[4*d +: 4] == 4'd0) begin
                        result[4*d +: 4] = 4'd9;
                    end else begin
                        result[4*d +: 4] = value[4*d +: 4] - 4'd1;
                        borrow = 1'b0;
                    end
                end
            end
            if (borrow)
                result[16] = 1'b0;
        end
        return result;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            clock_sample <= 1'b0;
            clock_prev   <= 1'b0;
            gate_sample  <= 1'b0;
        end else begin
            clock_sample <= counter_clock;
            clock_prev   <= clock_sample;
            gate_sample  <= counter_gate;
        end
    end

    assign count_edge = clock_prev && !clock_sample;
    assign count_dec  = decrement(count, bcd);

    always_comb begin
        count_next = count;
        case (mode)
            MODE_TERMINAL: begin
                if (gate_sample)
                    count_next = count_dec;
                if (load_pending)
                    count_next = preset_load;
            end
            MODE_RATE: begin
                if (gate_sample)
                    count_next = (count_dec == '0) ? preset_load : count_dec;
                if (load_pending)
                    count_next = preset_load;
            end
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count       <= '0;
            counter_out <= 1'b0;
        end else if (!counting) begin
            count <= '0;
            if (mode == MODE_TERMINAL)
                counter_out <= 1'b0;
            else if (mode == MODE_RATE)
                counter_out <= 1'b1;
        end else if (count_edge) begin
            count <= count_next;
            if (mode == MODE_TERMINAL)
                counter_out <= (count_next == '0);
            else if (mode == MODE_RATE)
                counter_out <= !(gate_sample && (count_next == 17'd1));
        end else if ((mode == MODE_RATE) && !gate_sample) begin
            counter_out <= 1'b1;
        end
    end

    a_bcd_digits: assert property (@(posedge clock) disable iff (reset)
        (bcd && counting) |-> (count[3:0] <= 4'd9 && count[7:4] <= 4'd9 &&
                               count[11:8] <= 4'd9 && count[15:12] <= 4'd9));

endmodule

`default_nettype wire

// ==== rtl/pit_readback_latch.sv ====
// Timer read-back latch
// Keeps a copy of the count that follows the live value until a
// latch command freezes it, and returns it one byte per read

`timescale 1ns/1ps
`default_nettype none

module pit_readback_latch import pit_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    read_counter,
    input  logic    latch_cmd,
    input  logic    config_write,
    input  rw_sel_t rw_sel,
    input  count_t  count,
    output byte_t   data_out
);

    logic   read_prev;
    logic   read_done;
    logic   read_step;
    logic   read_msb;
    logic   last_byte;
    logic   latched_flag;
    count_t count_latched;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            read_prev <= 1'b0;
        else
            read_prev <= read_counter;
    end

    // Byte is consumed when the read strobe falls
    assign read_done = read_prev && !read_counter;

    assign read_msb  = (rw_sel == RW_MSB) || ((rw_sel == RW_LSB_MSB) && read_step);
    assign last_byte = (rw_sel != RW_LSB_MSB) || read_step;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            read_step <= 1'b0;
        else if (config_write)
            read_step <= 1'b0;
        else if (read_done && (rw_sel == RW_LSB_MSB))
            read_step <= ~read_step;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            latched_flag <= 1'b0;
        else if (latch_cmd)
            latched_flag <= 1'b1;
        else if (latched_flag && read_done && last_byte)
            latched_flag <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (!latched_flag)
            count_latched <= count;
    end

    assign data_out = read_msb ? count_latched[15:8] : count_latched[7:0];

endmodule

`default_nettype wire

// ==== rtl/pit_counter_top.sv ====
// Interval timer counter channel
// One 8253-style counter running on the system clock, built from
// the mode register, preset loader, count engine and read-back latch

`timescale 1ns/1ps
`default_nettype none

module pit_counter_top import pit_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  byte_t data_in,
    input  logic  write_control,
    input  logic  write_counter,
    input  logic  read_counter,
    input  logic  counter_clock,
    input  logic  counter_gate,
    output byte_t data_out,
    output logic  counter_out
);

    rw_sel_t rw_sel;
    mode_t   mode;
    logic    bcd;
    logic    config_write;
    logic    latch_cmd;
    count_t  preset_load;
    logic    load_pending;
    logic    counting;
    count_t  count;
    logic    count_edge;

    pit_mode_register u_mode_register (
        .clock         (clock),
        .reset         (reset),
        .data_in       (data_in),
        .write_control (write_control),
        .rw_sel        (rw_sel),
        .mode          (mode),
        .bcd           (bcd),
        .config_write  (config_write),
        .latch_cmd     (latch_cmd)
    );

    pit_preset_loader u_preset_loader (
        .clock         (clock),
        .reset         (reset),
        .data_in       (data_in),
        .write_counter (write_counter),
        .config_write  (config_write),
        .rw_sel        (rw_sel),
        .count_edge    (count_edge),
        .preset_load   (preset_load),
        .load_pending  (load_pending),
        .counting      (counting)
    );

    pit_count_engine u_count_engine (
        .clock         (clock),
        .reset         (reset),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .mode          (mode),
        .bcd           (bcd),
        .preset_load   (preset_load),
        .load_pending  (load_pending),
        .counting      (counting),
        .count         (count),
        .count_edge    (count_edge),
        .counter_out   (counter_out)
    );

    pit_readback_latch u_readback_latch (
        .clock         (clock),
        .reset         (reset),
        .read_counter  (read_counter),
        .latch_cmd     (latch_cmd),
        .config_write  (config_write),
        .rw_sel        (rw_sel),
        .count         (count),
        .data_out      (data_out)
    );

endmodule

`default_nettype wire

// ==== testbench/pit_checker.sv ====
// Timer channel checker
// Watches the DUT pins, collects read bytes and output pulses,
// and compares them with the expected value of each test

`timescale 1ns/1ps
`default_nettype none

module pit_checker import pit_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  byte_t        data_out,
    input  logic         counter_out,
    input  logic         read_counter,
    input  logic         check_valid,
    input  logic [1:0]   check_kind,
    input  logic [15:0]  expected,
    input  logic [159:0] test_name,
    input  logic         run_done,
    output int           error_count
);

    int          pass_count;
    int          pulse_count;
    logic        out_prev;
    logic        read_prev;
    logic        summary_done;
    byte_t       byte_hold;
    logic [15:0] read_value;

    always @(negedge clock) begin
        logic [15:0] actual;
        if (reset) begin
            error_count  <= 0;
            pass_count   <= 0;
            pulse_count  <= 0;
            out_prev     <= 1'b0;
            read_prev    <= 1'b0;
            summary_done <= 1'b0;
            byte_hold    <= 8'h00;
            read_value   <= 16'h0000;
        end else begin
            out_prev  <= counter_out;
            read_prev <= read_counter;
            if (out_prev && !counter_out)
                pulse_count <= pulse_count + 1;
            if (read_counter)
                byte_hold <= data_out;
            // LSB arrives first, so each byte shifts in from the top
            if (read_prev && !read_counter)
                read_value <= {byte_hold, read_value[15:8]};

            if (check_valid) begin
                case (check_kind)
                    2'd0:    actual = {15'd0, counter_out};
                    2'd1:    actual = {8'h00, read_value[15:8]};
                    2'd2:    actual = read_value;
                    default: actual = pulse_count[15:0];
                endcase
                if (actual == expected) begin
                    pass_count <= pass_count + 1;
                    $display("[PASS] %0s value 0x%04h", test_name, actual);
                end else begin
                    error_count <= error_count + 1;
                    $display("[FAIL] %0s expected 0x%04h actual 0x%04h",
                             test_name, expected, actual);
                end
                pulse_count <= 0;
                read_value  <= 16'h0000;
            end

            if (run_done && !summary_done) begin
                summary_done <= 1'b1;
                $display("Tests run: %0d, passed: %0d, failed: %0d",
                         pass_count + error_count, pass_count, error_count);
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_pit_counter.sv ====
// Timer channel testbench
// Applies a table of control words, presets, counter clock edges
// and gate levels, then hands each expected result to the checker

`timescale 1ns/1ps
`default_nettype none

module tb_pit_counter;

    localparam int NUM_ENTRIES = 11;

    typedef struct packed {
        logic [159:0] name;
        logic         ctrl_en;
        logic [7:0]   ctrl;
        logic [1:0]   nbytes;
        logic [7:0]   b0;
        logic [7:0]   b1;
        logic [7:0]   edges;
        logic         latch;
        logic [7:0]   post_edges;
        logic         gate;
        logic [1:0]   kind;
        logic [15:0]  expected;
    } entry_t;

    logic clock, reset, write_control, write_counter, read_counter;
    logic counter_clock, counter_gate, counter_out;
    logic [7:0] data_in, data_out;
    logic check_valid, run_done, limit_ready;
    logic [1:0] check_kind;
    logic [15:0] check_expected, wide_preset;
    logic [159:0] check_name;
    int error_count, seed, max_edges, watchdog_cycles;
    entry_t tests [NUM_ENTRIES];

    pit_counter_top dut (
        .clock(clock), .reset(reset), .data_in(data_in),
        .write_control(write_control), .write_counter(write_counter),
        .read_counter(read_counter), .counter_clock(counter_clock),
        .counter_gate(counter_gate), .data_out(data_out), .counter_out(counter_out)
    );

    pit_checker u_checker (
        .clock(clock), .reset(reset), .data_out(data_out), .counter_out(counter_out),
        .read_counter(read_counter), .check_valid(check_valid), .check_kind(check_kind),
        .expected(check_expected), .test_name(check_name), .run_done(run_done),
        .error_count(error_count)
    );

    always #10 clock = ~clock;

    task automatic set_entry(input int idx, input logic [159:0] name, input logic ctrl_en,
                             input logic [7:0] ctrl, input logic [1:0] nbytes,
                             input logic [7:0] b0, input logic [7:0] b1,
                             input logic [7:0] edges, input logic latch,
                             input logic [7:0] post_edges, input logic gate,
                             input logic [1:0] kind, input logic [15:0] expected);
        tests[idx] = {name, ctrl_en, ctrl, nbytes, b0, b1, edges, latch, post_edges,
                      gate, kind, expected};
    endtask

    task automatic write_bus(input logic is_ctrl, input logic [7:0] value);
        @(posedge clock);
        data_in <= value;
        if (is_ctrl)
            write_control <= 1'b1;
        else
            write_counter <= 1'b1;
        @(posedge clock);
        write_control <= 1'b0;
        write_counter <= 1'b0;
    endtask

    // One counter clock period is 8 system clocks
    task automatic pulse_edges(input logic [7:0] n);
        repeat (n) begin
            @(posedge clock);
            counter_clock <= 1'b1;
            repeat (4) @(posedge clock);
            counter_clock <= 1'b0;
            repeat (3) @(posedge clock);
        end
    endtask

    task automatic read_byte();
        @(posedge clock);
        read_counter <= 1'b1;
        repeat (2) @(posedge clock);
        read_counter <= 1'b0;
        repeat (2) @(posedge clock);
    endtask

    task automatic apply_entry(input entry_t e);
        @(posedge clock);
        counter_gate <= e.gate;
        if (e.ctrl_en)
            write_bus(1'b1, e.ctrl);
        if (e.nbytes >= 2'd1)
            write_bus(1'b0, e.b0);
        if (e.nbytes == 2'd2)
            write_bus(1'b0, e.b1);
        pulse_edges(e.edges);
        if (e.latch)
            write_bus(1'b1, 8'h00);
        pulse_edges(e.post_edges);
        if (e.kind == 2'd1 || e.kind == 2'd2)
            read_byte();
        if (e.kind == 2'd2)
            read_byte();
        @(posedge clock);
        check_valid    <= 1'b1;
        check_kind     <= e.kind;
        check_expected <= e.expected;
        check_name     <= e.name;
        @(posedge clock);
        check_valid <= 1'b0;
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        data_in        = 8'h00;
        write_control  = 1'b0;
        write_counter  = 1'b0;
        read_counter   = 1'b0;
        counter_clock  = 1'b0;
        counter_gate   = 1'b1;
        check_valid    = 1'b0;
        check_kind     = 2'd0;
        check_expected = 16'h0000;
        check_name     = '0;
        run_done       = 1'b0;
        limit_ready    = 1'b0;
        seed           = 80;
        wide_preset = $random(seed);
        wide_preset = wide_preset | 16'h0100;

        // Check kind 0 reads the output level, 1 a single byte, 2 two bytes LSB first
        // and 3 the low pulses
        // The first edge after a write loads the preset and later edges decrement
        set_entry(0, "m0_low_for_n", 1, 8'h30, 2, 8'h05, 8'h00, 5, 0, 0, 1, 0, 16'h0000);
        set_entry(1, "m0_high_n_plus_1", 0, 8'h00, 0, 8'h00, 8'h00, 1, 0, 0, 1, 0, 16'h0001);
        set_entry(2, "latch_frozen", 1, 8'h30, 2, wide_preset[7:0], wide_preset[15:8],
                  4, 1, 2, 1, 2, wide_preset - 16'd3);
        set_entry(3, "latch_later", 0, 8'h00, 0, 8'h00, 8'h00, 3, 1, 0, 1, 2,
                  wide_preset - 16'd8);
        set_entry(4, "bcd_0100", 1, 8'h31, 2, 8'h00, 8'h01, 2, 1, 0, 1, 2, 16'h0099);
        set_entry(5, "m2_load", 1, 8'h34, 2, 8'h04, 8'h00, 1, 0, 0, 1, 3, 16'd0);
        set_entry(6, "m2_three_pulses", 0, 8'h00, 0, 8'h00, 8'h00, 12, 0, 0, 1, 3, 16'd3);
        set_entry(7, "gate_low_hold", 1, 8'h30, 2, 8'h20, 8'h00, 5, 1, 0, 0, 2, 16'h0020);
        set_entry(8, "gate_resume", 0, 8'h00, 0, 8'h00, 8'h00, 3, 1, 0, 1, 2, 16'h001d);
        set_entry(9, "lsb_only", 1, 8'h20, 1, 8'h05, 8'h00, 1, 1, 0, 1, 1, 16'h0005);
        set_entry(10, "msb_only", 1, 8'h10, 1, 8'h05, 8'h00, 3, 1, 0, 1, 1, 16'h0004);

        max_edges = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (int'(tests[i].edges) + int'(tests[i].post_edges) > max_edges)
                max_edges = int'(tests[i].edges) + int'(tests[i].post_edges);
        end
        watchdog_cycles = NUM_ENTRIES * max_edges * 8 + NUM_ENTRIES * 64 + 200;
        limit_ready = 1'b1;

        repeat (16) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++)
            apply_entry(tests[i]);

        @(posedge clock);
        run_done <= 1'b1;
        repeat (3) @(posedge clock);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (limit_ready);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog timeout: the test table did not finish in %0d clocks",
                 watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/pit_pkg.sv
rtl/pit_mode_register.sv
rtl/pit_preset_loader.sv
rtl/pit_count_engine.sv
rtl/pit_readback_latch.sv
rtl/pit_counter_top.sv
testbench/pit_checker.sv
testbench/tb_pit_counter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the timer channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_pit_counter -o sim_pit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_pit > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation run returned status $run_status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1
